// ==== common/mipsPkg.sv ====
// MIPS subset shared definitions
package mipsPkg;

  // opcodes of the kept subset
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opAndi  = 6'h0c,
    opOri   = 6'h0d,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type function field
  typedef enum logic [5:0] {
    fnSll = 6'h00,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluSll
  } aluOpT;

  // immediate is bits 15:0, jump target bits 25:0
  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } instrT;

  typedef struct packed {
    logic  regDst;
    logic  aluSrc;
    logic  zeroExt;
    logic  memToReg;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  jump;
    aluOpT aluOp;
  } ctrlT;

  localparam logic [31:0] pcIncr = 32'd4;
  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;
  localparam int imemAddrBits = $clog2(imemDepth);
  localparam int dmemAddrBits = $clog2(dmemDepth);
  // sll r0, r0, 0
  localparam logic [31:0] nopInstr = 32'h0000_0000;

endpackage

// ==== core/controller.sv ====
// Instruction decoder
`timescale 1ns/1ps

module controller import mipsPkg::*; (
  input  opcodeT opcode,
  input  functT  funct,
  output ctrlT   ctrl
);

  always_comb begin
    // unknown opcodes fall out as a no-op
    ctrl = '0;
    case (opcode)
      opRType: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnSll: ctrl.aluOp = aluSll;
          // unsupported funct writes nothing
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opAndi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAnd;
      end
      opOri: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluOr;
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== core/regFile.sv ====
// Register file
`timescale 1ns/1ps

module regFile (
  input  logic        CLK,
  input  logic        writeEnable,
  input  logic [4:0]  readAddr1,
  input  logic [4:0]  readAddr2,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeData,
  output logic [31:0] readData1,
  output logic [31:0] readData2
);

  logic [31:0] regs [32];

  // register zero is never written
  always_ff @(posedge CLK) begin
    if (writeEnable && writeAddr != 5'd0) begin
      regs[writeAddr] <= writeData;
    end
  end

  // combinational reads, zero forced for r0
  assign readData1 = (readAddr1 == 5'd0) ? 32'd0 : regs[readAddr1];
  assign readData2 = (readAddr2 == 5'd0) ? 32'd0 : regs[readAddr2];

endmodule

// ==== core/alu.sv ====
// Arithmetic and logic unit
`timescale 1ns/1ps

module alu import mipsPkg::*; (
  input  aluOpT       aluOp,
  input  logic [4:0]  shamt,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        zero
);

  always_comb begin
    case (aluOp)
      aluAdd: begin
        result = a + b;
      end
      aluSub: begin
        result = a - b;
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluSlt: begin
        // signed compare
        result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      end
      aluSll: begin
        // shift operand comes from rt
        result = b << shamt;
      end
      default: begin
        result = 32'd0;
      end
    endcase
  end

  // beq looks at this after a subtract
  assign zero = (result == 32'd0);

endmodule

// ==== core/core.sv ====
// Single-cycle processor core
`timescale 1ns/1ps

module core import mipsPkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  instrT       instr,
  input  logic [31:0] readData,
  output logic [31:0] pc,
  output logic [31:0] aluOut,
  output logic [31:0] writeData,
  output logic        memRead,
  output logic        memWrite
);

  ctrlT        decCtrl;
  ctrlT        ctrl;
  logic [4:0]  destReg;
  logic [31:0] regData1;
  logic [31:0] regData2;
  logic [31:0] signImm;
  logic [31:0] extImm;
  logic [31:0] aluB;
  logic [31:0] resultData;
  logic        aluZero;
  logic [31:0] pcPlus4;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  controller controller (
    .opcode (instr.opcode),
    .funct  (instr.funct),
    .ctrl   (decCtrl)
  );

  // nothing writes while in reset
  assign ctrl = rst ? ctrlT'('0) : decCtrl;

  // immediate extension
  assign signImm = {{16{instr[15]}}, instr[15:0]};
  assign extImm  = ctrl.zeroExt ? {16'd0, instr[15:0]} : signImm;

  assign destReg    = ctrl.regDst ? instr.rd : instr.rt;
  assign aluB       = ctrl.aluSrc ? extImm : regData2;
  assign resultData = ctrl.memToReg ? readData : aluOut;

  regFile regFile (
    .CLK         (CLK),
    .writeEnable (ctrl.regWrite),
    .readAddr1   (instr.rs),
    .readAddr2   (instr.rt),
    .writeAddr   (destReg),
    .writeData   (resultData),
    .readData1   (regData1),
    .readData2   (regData2)
  );

  alu alu (
    .aluOp  (ctrl.aluOp),
    .shamt  (instr.shamt),
    .a      (regData1),
    .b      (aluB),
    .result (aluOut),
    .zero   (aluZero)
  );

  // next pc selection
  assign pcPlus4      = pc + pcIncr;
  assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    nextPc = pcPlus4;
    if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && aluZero) begin
      nextPc = branchTarget;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc <= 32'd0;
    end else begin
      pc <= nextPc;
    end
  end

  assign writeData = regData2;
  assign memRead   = ctrl.memRead;
  assign memWrite  = ctrl.memWrite;

endmodule

// ==== verilog/instrMem.sv ====
// Instruction memory with load port
`timescale 1ns/1ps

module instrMem import mipsPkg::*; (
  input  logic                    CLK,
  input  logic                    progWe,
  input  logic [imemAddrBits-1:0] progAddr,
  input  logic [31:0]             progData,
  input  logic [31:0]             pc,
  output instrT                   instr
);

  logic [31:0] mem [imemDepth];

  // unwritten words decode as nop
  initial begin
    for (int i = 0; i < imemDepth; i++) begin
      mem[i] = nopInstr;
    end
  end

  always @(posedge CLK) begin
    if (progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // word fetch, byte offset dropped
  assign instr = mem[pc[imemAddrBits+1:2]];

endmodule

// ==== verilog/dataMem.sv ====
// Data memory
`timescale 1ns/1ps

module dataMem import mipsPkg::*; (
  input  logic        CLK,
  input  logic [31:0] addr,
  input  logic [31:0] writeData,
  input  logic        memRead,
  input  logic        memWrite,
  output logic [31:0] readData
);

  logic [31:0]             mem [dmemDepth];
  logic [dmemAddrBits-1:0] wordIdx;

  // byte address to word index
  assign wordIdx = addr[dmemAddrBits+1:2];

  always_ff @(posedge CLK) begin
    if (memWrite) begin
      mem[wordIdx] <= writeData;
    end
  end

  // read data only when a load asks for it
  assign readData = memRead ? mem[wordIdx] : 32'd0;

endmodule

// ==== verilog/mipsTop.sv ====
// MIPS processor subsystem top
`timescale 1ns/1ps

module mipsTop import mipsPkg::*; (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    progWe,
  input  logic [imemAddrBits-1:0] progAddr,
  input  logic [31:0]             progData,
  output logic                    storeValid,
  output logic [31:0]             storeAddr,
  output logic [31:0]             storeData
);

  logic [31:0] pc;
  instrT       instr;
  logic [31:0] readData;
  logic        memRead;

  // store traffic taps the data memory bus directly
  core core (
    .CLK       (CLK),
    .rst       (rst),
    .instr     (instr),
    .readData  (readData),
    .pc        (pc),
    .aluOut    (storeAddr),
    .writeData (storeData),
    .memRead   (memRead),
    .memWrite  (storeValid)
  );

  instrMem instrMem (
    .CLK      (CLK),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .pc       (pc),
    .instr    (instr)
  );

  dataMem dataMem (
    .CLK       (CLK),
    .addr      (storeAddr),
    .writeData (storeData),
    .memRead   (memRead),
    .memWrite  (storeValid),
    .readData  (readData)
  );

endmodule

// ==== testbench/clockGen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module clockGen (
  output logic CLK
);

  localparam int halfPeriodNs = 50;

  initial begin
    CLK = 1'b0;
  end

  always #halfPeriodNs CLK = ~CLK;

endmodule

// ==== testbench/mipsTop_sva.sv ====
// Store traffic assertions
`timescale 1ns/1ps

module mipsTopSva (
  input logic        CLK,
  input logic        rst,
  input logic        storeValid,
  input logic [31:0] storeAddr,
  input logic [31:0] storeData
);

  // core masks all control while in reset
  assert property (@(posedge CLK) rst |-> !storeValid)
    else $error("store issued while reset is high");

  assert property (@(posedge CLK) disable iff (rst) storeValid |-> storeAddr[1:0] == 2'b00)
    else $error("store address is not word aligned");

  assert property (@(posedge CLK) disable iff (rst)
    storeValid |-> !$isunknown({storeAddr, storeData}))
    else $error("store address or data has unknown bits");

endmodule

bind mipsTop mipsTopSva mipsTopSvaInst (
  .CLK        (CLK),
  .rst        (rst),
  .storeValid (storeValid),
  .storeAddr  (storeAddr),
  .storeData  (storeData)
);

// ==== testbench/mipsTb.sv ====
// MIPS subsystem testbench
`timescale 1ns/1ps

module mipsTb import mipsPkg::*; ();

  localparam int clkPeriodNs = 100;
  localparam int stallLimit = 40;
  localparam int numTests = 6;
  localparam int watchdogNs = numTests * (4 + stallLimit + imemDepth) * clkPeriodNs;

  logic                    CLK;
  logic                    rst;
  logic                    progWe;
  logic [imemAddrBits-1:0] progAddr;
  logic [31:0]             progData;
  logic                    storeValid;
  logic [31:0]             storeAddr;
  logic [31:0]             storeData;

  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          storeIdx;
  string       testName;

  clockGen clkGen (
    .CLK (CLK)
  );

  mipsTop mipsTop_inst (
    .CLK        (CLK),
    .rst        (rst),
    .progWe     (progWe),
    .progAddr   (progAddr),
    .progData   (progData),
    .storeValid (storeValid),
    .storeAddr  (storeAddr),
    .storeData  (storeData)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // instruction assembly from fields
  task automatic emitR(input functT fn, input int rd, input int rs, input int rt,
                       input int shamt);
    prog.push_back({opRType, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn});
  endtask

  task automatic emitI(input opcodeT op, input int rt, input int rs, input logic [15:0] imm);
    prog.push_back({op, 5'(rs), 5'(rt), imm});
  endtask

  task automatic emitJ(input int target);
    prog.push_back({opJ, 26'(target)});
  endtask

  function automatic logic [31:0] signExt(input logic [15:0] imm);
    return 32'($signed(imm));
  endfunction

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic startTest(input string name);
    testName = name;
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  // program goes in while reset holds the core
  task automatic loadProgram();
    @(posedge CLK);
    #1;
    rst = 1'b1;
    for (int i = 0; i < imemDepth; i++) begin
      progWe   = 1'b1;
      progAddr = imemAddrBits'(i);
      progData = (i < prog.size()) ? prog[i] : nopInstr;
      @(posedge CLK);
      #1;
    end
    progWe = 1'b0;
    rst    = 1'b0;
  endtask

  task automatic runProgram();
    int haltIdx;
    int cycles;
    // park the core in a jump to itself
    haltIdx = prog.size();
    emitJ(haltIdx);
    loadProgram();
    cycles = 0;
    while (storeIdx < expAddr.size() && cycles < stallLimit) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    // a short tail catches any extra store
    repeat (2) @(posedge CLK);
    #1;
    assert (storeIdx == expAddr.size())
      else failRun($sformatf("%s stalled, only %0d of %0d stores seen within %0d cycles",
                             testName, storeIdx, expAddr.size(), stallLimit));
  endtask

  // compare each store with the next expected pair
  always @(posedge CLK) begin
    if (rst) begin
      storeIdx = 0;
    end else if (storeValid) begin
      assert (storeIdx < expAddr.size())
        else failRun($sformatf("unexpected store to %h in test %s", storeAddr, testName));
      assert (storeAddr == expAddr[storeIdx])
        else failRun($sformatf("error %s store address expected %h actual %h",
                               testName, expAddr[storeIdx], storeAddr));
      assert (storeData == expData[storeIdx])
        else failRun($sformatf("error %s store data expected %h actual %h",
                               testName, expData[storeIdx], storeData));
      storeIdx = storeIdx + 1;
    end
  end

  task automatic immediateArith();
    logic [15:0] immA;
    logic [15:0] immB;
    logic [15:0] immC;
    logic [15:0] immD;
    logic [31:0] r1;
    startTest("immediateArith");
    immA = 16'($urandom);
    immB = 16'($urandom);
    immC = 16'($urandom);
    immD = 16'($urandom);
    r1 = signExt(immA);
    emitI(opAddi, 1, 0, immA);
    emitI(opAndi, 2, 1, immB);
    emitI(opOri, 3, 1, immC);
    emitI(opAddi, 4, 1, immD);
    emitI(opSw, 1, 0, 16'd0);
    emitI(opSw, 2, 0, 16'd4);
    emitI(opSw, 3, 0, 16'd8);
    emitI(opSw, 4, 0, 16'd12);
    expectStore(32'd0, r1);
    expectStore(32'd4, r1 & {16'd0, immB});
    expectStore(32'd8, r1 | {16'd0, immC});
    expectStore(32'd12, r1 + signExt(immD));
    runProgram();
  endtask

  task automatic rTypeOps();
    startTest("rTypeOps");
    // r1 = -7, r2 = 5
    emitI(opAddi, 1, 0, 16'hfff9);
    emitI(opAddi, 2, 0, 16'd5);
    emitR(fnAdd, 3, 1, 2, 0);
    emitR(fnSub, 4, 2, 1, 0);
    emitR(fnAnd, 5, 1, 2, 0);
    emitR(fnOr, 6, 1, 2, 0);
    emitR(fnSlt, 7, 1, 2, 0);
    emitR(fnSlt, 8, 2, 1, 0);
    emitR(fnSll, 9, 0, 2, 3);
    for (int r = 3; r <= 9; r++) begin
      emitI(opSw, r, 0, 16'(4 * r + 4));
    end
    expectStore(32'd16, 32'hffff_fffe);
    expectStore(32'd20, 32'd12);
    expectStore(32'd24, 32'd1);
    expectStore(32'd28, 32'hffff_fffd);
    expectStore(32'd32, 32'd1);
    expectStore(32'd36, 32'd0);
    expectStore(32'd40, 32'd40);
    runProgram();
  endtask

  task automatic loadStore();
    logic [15:0] imm;
    startTest("loadStore");
    imm = 16'($urandom);
    emitI(opAddi, 1, 0, imm);
    emitI(opSw, 1, 0, 16'd32);
    emitI(opLw, 2, 0, 16'd32);
    emitI(opSw, 2, 0, 16'd36);
    // base register plus offset
    emitI(opAddi, 3, 0, 16'd40);
    emitI(opSw, 1, 3, 16'd8);
    expectStore(32'd32, signExt(imm));
    expectStore(32'd36, signExt(imm));
    expectStore(32'd48, signExt(imm));
    runProgram();
  endtask

  task automatic regZero();
    startTest("regZero");
    // a store at word 0 sits at the pc through reset
    emitI(opSw, 0, 0, 16'd48);
    emitI(opAddi, 0, 0, 16'h1234);
    emitI(opSw, 0, 0, 16'd52);
    emitI(opAddi, 5, 0, 16'h0055);
    emitR(fnAdd, 0, 5, 5, 0);
    emitI(opSw, 0, 0, 16'd56);
    expectStore(32'd48, 32'd0);
    expectStore(32'd52, 32'd0);
    expectStore(32'd56, 32'd0);
    runProgram();
  endtask

  task automatic branches();
    startTest("branches");
    emitI(opAddi, 1, 0, 16'd9);
    emitI(opAddi, 2, 0, 16'd9);
    // taken, skips the next store
    emitI(opBeq, 2, 1, 16'd1);
    emitI(opSw, 1, 0, 16'd60);
    emitI(opAddi, 3, 0, 16'd4);
    // not taken
    emitI(opBeq, 3, 1, 16'd1);
    emitI(opSw, 3, 0, 16'd64);
    emitI(opSw, 2, 0, 16'd68);
    expectStore(32'd64, 32'd4);
    expectStore(32'd68, 32'd9);
    runProgram();
  endtask

  task automatic jumpLoop();
    int count;
    startTest("jumpLoop");
    count = 3 + int'($urandom % 3);
    emitJ(2);
    emitI(opSw, 0, 0, 16'd100);
    emitI(opAddi, 1, 0, 16'(count));
    emitI(opAddi, 2, 0, 16'd80);
    // loop body at word 4
    emitI(opSw, 1, 2, 16'd0);
    emitI(opAddi, 2, 2, 16'd4);
    emitI(opAddi, 1, 1, 16'hffff);
    emitI(opBeq, 0, 1, 16'd1);
    emitJ(4);
    emitI(opSw, 2, 0, 16'd200);
    for (int k = 0; k < count; k++) begin
      expectStore(32'(80 + 4 * k), 32'(count - k));
    end
    expectStore(32'd200, 32'(80 + 4 * count));
    runProgram();
  endtask

  initial begin
    #(watchdogNs);
    failRun("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    rst      = 1'b1;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    void'($urandom(32'h6c79));
    repeat (4) @(posedge CLK);
    immediateArith();
    rTypeOps();
    loadStore();
    regZero();
    branches();
    jumpLoop();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== mipsTop.f ====
common/mipsPkg.sv
core/controller.sv
core/regFile.sv
core/alu.sv
core/core.sv
verilog/instrMem.sv
verilog/dataMem.sv
verilog/mipsTop.sv
testbench/clockGen.sv
testbench/mipsTop_sva.sv
testbench/mipsTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module mipsTb -f mipsTop.f -o mipsTb &&
  ./obj_dir/mipsTb | tee /dev/stderr | grep -q "Test OK" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
